//--- all.f
+incdir+include
verilog/gpio_jtag_pkg.sv
verilog/jtag_pin_sampler.sv
verilog/jtag_tap_ctrl.sv
verilog/gpio_port.sv
verilog/gpio_jtag_top.sv
verification/tb_clock_gen.sv
verification/gpio_jtag_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert \
  --top-module gpio_jtag_tb -f all.f -o gpio_jtag_sim \
  && ./obj_dir/gpio_jtag_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

//--- verification/gpio_jtag_tb.sv
`timescale 1ns/1ps
`include "gpio_jtag_settings.svh"

module gpio_jtag_tb;

  logic                      clock;
  logic                      reset;
  gpio_jtag_pkg::jtag_pins_t jtag_pins;
  logic                      tdo;
  logic [`GPIO_WIDTH-1:0]    gpio_in;
  logic [`GPIO_WIDTH-1:0]    gpio_out;
  // reference model: active instruction and output register
  logic [`IR_WIDTH-1:0]      model_ir;
  logic [`GPIO_WIDTH-1:0]    model_gpio_out;
  logic [31:0]               lfsr_q;
  int                        mismatches;
  int                        timeouts;

  tb_clock_gen tb_clock_gen_i (
    .clock_o (clock),
    .reset_o (reset)
  );

  gpio_jtag_top gpio_jtag_top_i (
    .clock_i (clock),
    .reset_i (reset),
    .jtag_i  (jtag_pins),
    .tdo_o   (tdo),
    .gpio_i  (gpio_in),
    .gpio_o  (gpio_out)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value[i] = lfsr_q[0];
    end
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("mismatch %s expected %h actual %h", test_name, expected, actual);
      mismatches++;
    end
  endtask

  // one tck period, tdo read just before the rising edge
  task automatic clock_tck(input logic tms, input logic tdi, output logic tdo_bit);
    @(negedge clock);
    jtag_pins.tms = tms;
    jtag_pins.tdi = tdi;
    repeat (8) @(negedge clock);
    tdo_bit = tdo;
    jtag_pins.tck = 1'b1;
    repeat (8) @(negedge clock);
    jtag_pins.tck = 1'b0;
  endtask

  task automatic run_idle();
    logic tdo_bit;
    clock_tck(1'b0, 1'b0, tdo_bit);
  endtask

  // from run-test/idle through a full scan and back, lsb first
  task automatic shift_scan(input logic is_ir, input int len, input logic [31:0] bits_in,
                            output logic [31:0] bits_out);
    logic tdo_bit;
    bits_out = '0;
    clock_tck(1'b1, 1'b0, tdo_bit);
    if (is_ir) begin
      clock_tck(1'b1, 1'b0, tdo_bit);
    end
    // capture, then into shift
    clock_tck(1'b0, 1'b0, tdo_bit);
    clock_tck(1'b0, 1'b0, tdo_bit);
    // last bit leaves through exit1
    for (int i = 0; i < len; i++) begin
      clock_tck(i == len - 1, bits_in[i], tdo_bit);
      bits_out[i] = tdo_bit;
    end
    clock_tck(1'b1, 1'b0, tdo_bit);
    clock_tck(1'b0, 1'b0, tdo_bit);
  endtask

  task automatic tms_reset();
    logic tdo_bit;
    repeat (5) clock_tck(1'b1, 1'b0, tdo_bit);
    run_idle();
  endtask

  task automatic pulse_trst();
    @(negedge clock);
    jtag_pins.trst_n = 1'b0;
    repeat (8) @(negedge clock);
    jtag_pins.trst_n = 1'b1;
    repeat (8) @(negedge clock);
    run_idle();
  endtask

  task automatic wait_gpio_out(input logic [`GPIO_WIDTH-1:0] expected);
    int cycles;
    cycles = 0;
    while (gpio_out !== expected && cycles < 64) begin
      @(negedge clock);
      cycles++;
    end
    assert (cycles < 64) else begin
      $display("gpio_o did not take the written value within 64 cycles");
      timeouts++;
    end
    check_value("gpio_write_out", 32'(expected), 32'(gpio_out));
  endtask

  // expected dr scan output from the selected register
  function automatic logic [31:0] model_dr_out(input logic [31:0] bits_in, input int len);
    logic [31:0] mask;
    mask = (len >= 32) ? 32'hffff_ffff : ((32'h1 << len) - 32'h1);
    case (model_ir)
      `IR_IDCODE:      return `JTAG_IDCODE;
      `IR_GPIO_SAMPLE: return 32'(gpio_in);
      `IR_GPIO_WRITE:  return 32'(model_gpio_out);
      // bypass: a zero, then the input one position late
      default:         return (bits_in << 1) & mask;
    endcase
  endfunction

  task automatic load_instruction(input string test_name, input logic [`IR_WIDTH-1:0] code);
    logic [31:0] captured;
    shift_scan(1'b1, `IR_WIDTH, 32'(code), captured);
    check_value(test_name, 32'h0000_0001, captured);
    model_ir = code;
  endtask

  task automatic scan_and_check(input string test_name, input int len);
    logic [31:0] bits_in;
    logic [31:0] bits_out;
    logic [31:0] expected;
    random_bits(len, bits_in);
    expected = model_dr_out(bits_in, len);
    shift_scan(1'b0, len, bits_in, bits_out);
    check_value(test_name, expected, bits_out);
    if (model_ir == `IR_GPIO_WRITE) begin
      model_gpio_out = bits_in[`GPIO_WIDTH-1:0];
      wait_gpio_out(model_gpio_out);
    end
  endtask

  initial begin
    int                   cycles;
    logic [31:0]          value;
    logic [`IR_WIDTH-1:0] code;
    jtag_pins = '{tck: 1'b0, tms: 1'b1, tdi: 1'b0, trst_n: 1'b1};
    gpio_in = '0;
    model_ir = `IR_IDCODE;
    model_gpio_out = '0;
    lfsr_q = 32'h4afa_81c5;
    mismatches = 0;
    timeouts = 0;
    cycles = 0;
    while (reset !== 1'b0 && cycles < 100) begin
      @(negedge clock);
      cycles++;
    end
    assert (reset === 1'b0) else begin
      $display("reset was not released within 100 cycles");
      timeouts++;
    end
    check_value("tdo_after_reset", 32'h0, 32'(tdo));
    check_value("gpio_after_reset", 32'h0, 32'(gpio_out));

    // idcode is selected straight out of reset
    run_idle();
    scan_and_check("idcode_after_reset", 32);

    // ir capture, then both ways back to idcode
    load_instruction("ir_capture", `IR_BYPASS);
    pulse_trst();
    model_ir = `IR_IDCODE;
    scan_and_check("idcode_after_trst", 32);
    load_instruction("ir_capture_before_tms_reset", `IR_GPIO_WRITE);
    tms_reset();
    model_ir = `IR_IDCODE;
    scan_and_check("idcode_after_tms_reset", 32);

    // bypass and an undefined opcode
    load_instruction("ir_capture_bypass", `IR_BYPASS);
    repeat (4) scan_and_check("bypass", 16);
    random_bits(`IR_WIDTH, value);
    code = value[`IR_WIDTH-1:0];
    if (code inside {`IR_IDCODE, `IR_GPIO_SAMPLE, `IR_GPIO_WRITE, `IR_BYPASS}) begin
      code = code ^ 5'h04;
    end
    load_instruction("ir_capture_undefined", code);
    repeat (4) scan_and_check("bypass_undefined", 16);

    // output writes, each scan returns the previous value
    load_instruction("ir_capture_write", `IR_GPIO_WRITE);
    repeat (8) scan_and_check("gpio_write", `GPIO_WIDTH);

    // input sampling, gpio_in held across the scan
    load_instruction("ir_capture_sample", `IR_GPIO_SAMPLE);
    repeat (8) begin
      random_bits(`GPIO_WIDTH, value);
      @(negedge clock);
      gpio_in = value[`GPIO_WIDTH-1:0];
      scan_and_check("gpio_sample", `GPIO_WIDTH);
      check_value("gpio_out_held", 32'(model_gpio_out), 32'(gpio_out));
    end

    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clock_o = 1'b0;
    forever #2 clock_o = ~clock_o;
  end

  // reset held five cycles, dropped on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

//--- verilog/gpio_jtag_top.sv
`timescale 1ns/1ps
`include "gpio_jtag_settings.svh"

module gpio_jtag_top (
  input  logic                      clock_i,
  input  logic                      reset_i,
  // jtag port, sampled with clock_i
  input  gpio_jtag_pkg::jtag_pins_t jtag_i,
  output logic                      tdo_o,
  // gpio pins
  input  logic [`GPIO_WIDTH-1:0]    gpio_i,
  output logic [`GPIO_WIDTH-1:0]    gpio_o
);

  gpio_jtag_pkg::jtag_strobe_t jtag_strobe;
  gpio_jtag_pkg::gpio_write_t  gpio_write;
  // synchronized inputs for gpio_sample
  logic [`GPIO_WIDTH-1:0]      gpio_in_sync;

  // pins into edge strobes
  jtag_pin_sampler jtag_pin_sampler_i (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .pins_i   (jtag_i),
    .strobe_o (jtag_strobe)
  );

  // tap with idcode, bypass and the gpio registers
  jtag_tap_ctrl jtag_tap_ctrl_i (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .strobe_i     (jtag_strobe),
    .gpio_in_i    (gpio_in_sync),
    .gpio_out_i   (gpio_o),
    .tdo_o        (tdo_o),
    .gpio_write_o (gpio_write)
  );

  // output register and input sync
  gpio_port gpio_port_i (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .gpio_i       (gpio_i),
    .gpio_write_i (gpio_write),
    .gpio_o       (gpio_o),
    .gpio_in_o    (gpio_in_sync)
  );

endmodule

//--- verilog/gpio_port.sv
`timescale 1ns/1ps
`include "gpio_jtag_settings.svh"

module gpio_port (
  input  logic                       clock_i,
  input  logic                       reset_i,
  input  logic [`GPIO_WIDTH-1:0]     gpio_i,
  input  gpio_jtag_pkg::gpio_write_t gpio_write_i,
  output logic [`GPIO_WIDTH-1:0]     gpio_o,
  output logic [`GPIO_WIDTH-1:0]     gpio_in_o
);

  // output register, written from the tap
  logic [`GPIO_WIDTH-1:0] out_q;
  // input synchronizer stages
  logic [`GPIO_WIDTH-1:0] in_sync1_q;
  logic [`GPIO_WIDTH-1:0] in_sync2_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      out_q <= '0;
    end else if (gpio_write_i.strobe) begin
      out_q <= gpio_write_i.data;
    end
  end

  // external pins are asynchronous to clock_i
  always_ff @(posedge clock_i) begin
    in_sync1_q <= gpio_i;
    in_sync2_q <= in_sync1_q;
  end

  assign gpio_o    = out_q;
  assign gpio_in_o = in_sync2_q;

  // outputs only move on a tap write
  gpio_change_needs_write_a: assert property (
    @(posedge clock_i) disable iff (reset_i)
    $changed(gpio_o) |-> $past(gpio_write_i.strobe)
  );

endmodule

//--- verilog/jtag_tap_ctrl.sv
`timescale 1ns/1ps
`include "gpio_jtag_settings.svh"

module jtag_tap_ctrl (
  input  logic                        clock_i,
  input  logic                        reset_i,
  input  gpio_jtag_pkg::jtag_strobe_t strobe_i,
  input  logic [`GPIO_WIDTH-1:0]      gpio_in_i,
  input  logic [`GPIO_WIDTH-1:0]      gpio_out_i,
  output logic                        tdo_o,
  output gpio_jtag_pkg::gpio_write_t  gpio_write_o
);

  gpio_jtag_pkg::tap_state_e state_q;
  gpio_jtag_pkg::tap_state_e state_next;
  // active instruction and its shift stage
  logic [`IR_WIDTH-1:0]      ir_q;
  logic [`IR_WIDTH-1:0]      ir_shift_q;
  // shared dr shift stage, sized for the widest register
  logic [31:0]               dr_shift_q;
  logic [31:0]               dr_capture;
  logic [31:0]               dr_shifted;
  logic                      tdo_q;
  logic                      shift_active;
  // high in the first cycle spent in update-dr
  logic                      upd_dr_entry_q;
  logic                      write_strobe_q;

  // standard tap transition table, advanced by tms
  function automatic gpio_jtag_pkg::tap_state_e tap_next(
    input gpio_jtag_pkg::tap_state_e state,
    input logic                      tms
  );
    gpio_jtag_pkg::tap_state_e nxt;
    case (state)
      gpio_jtag_pkg::TAP_TLR:
        nxt = tms ? gpio_jtag_pkg::TAP_TLR : gpio_jtag_pkg::TAP_RUN_IDLE;
      gpio_jtag_pkg::TAP_RUN_IDLE:
        nxt = tms ? gpio_jtag_pkg::TAP_SELECT_DR : gpio_jtag_pkg::TAP_RUN_IDLE;
      gpio_jtag_pkg::TAP_SELECT_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_SELECT_IR : gpio_jtag_pkg::TAP_CAPTURE_DR;
      gpio_jtag_pkg::TAP_CAPTURE_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT1_DR : gpio_jtag_pkg::TAP_SHIFT_DR;
      gpio_jtag_pkg::TAP_SHIFT_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT1_DR : gpio_jtag_pkg::TAP_SHIFT_DR;
      gpio_jtag_pkg::TAP_EXIT1_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_UPDATE_DR : gpio_jtag_pkg::TAP_PAUSE_DR;
      gpio_jtag_pkg::TAP_PAUSE_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT2_DR : gpio_jtag_pkg::TAP_PAUSE_DR;
      gpio_jtag_pkg::TAP_EXIT2_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_UPDATE_DR : gpio_jtag_pkg::TAP_SHIFT_DR;
      gpio_jtag_pkg::TAP_UPDATE_DR:
        nxt = tms ? gpio_jtag_pkg::TAP_SELECT_DR : gpio_jtag_pkg::TAP_RUN_IDLE;
      gpio_jtag_pkg::TAP_SELECT_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_TLR : gpio_jtag_pkg::TAP_CAPTURE_IR;
      gpio_jtag_pkg::TAP_CAPTURE_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT1_IR : gpio_jtag_pkg::TAP_SHIFT_IR;
      gpio_jtag_pkg::TAP_SHIFT_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT1_IR : gpio_jtag_pkg::TAP_SHIFT_IR;
      gpio_jtag_pkg::TAP_EXIT1_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_UPDATE_IR : gpio_jtag_pkg::TAP_PAUSE_IR;
      gpio_jtag_pkg::TAP_PAUSE_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_EXIT2_IR : gpio_jtag_pkg::TAP_PAUSE_IR;
      gpio_jtag_pkg::TAP_EXIT2_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_UPDATE_IR : gpio_jtag_pkg::TAP_SHIFT_IR;
      gpio_jtag_pkg::TAP_UPDATE_IR:
        nxt = tms ? gpio_jtag_pkg::TAP_SELECT_DR : gpio_jtag_pkg::TAP_RUN_IDLE;
      default:
        nxt = gpio_jtag_pkg::TAP_TLR;
    endcase
    return nxt;
  endfunction

  assign state_next = tap_next(state_q, strobe_i.tms);

  // capture value and shift path per selected data register
  // unknown opcodes fall back to the 1-bit bypass register
  always_comb begin
    case (ir_q)
      `IR_IDCODE: begin
        dr_capture = `JTAG_IDCODE;
        dr_shifted = {strobe_i.tdi, dr_shift_q[31:1]};
      end
      `IR_GPIO_SAMPLE, `IR_GPIO_WRITE: begin
        dr_capture = (ir_q == `IR_GPIO_SAMPLE) ? 32'(gpio_in_i) : 32'(gpio_out_i);
        dr_shifted = {{(32 - `GPIO_WIDTH){1'b0}}, strobe_i.tdi,
                      dr_shift_q[`GPIO_WIDTH-1:1]};
      end
      default: begin
        dr_capture = '0;
        dr_shifted = {31'b0, strobe_i.tdi};
      end
    endcase
  end

  // state and instruction; trst acts like reset
  always_ff @(posedge clock_i) begin
    if (reset_i || strobe_i.trst) begin
      state_q <= gpio_jtag_pkg::TAP_TLR;
      ir_q    <= `IR_IDCODE;
    end else if (strobe_i.tck_rise) begin
      state_q <= state_next;
      if (state_next == gpio_jtag_pkg::TAP_TLR) begin
        ir_q <= `IR_IDCODE;
      end else if (state_next == gpio_jtag_pkg::TAP_UPDATE_IR) begin
        ir_q <= ir_shift_q;
      end
    end
  end

  // capture and shift act on the state held at the rise
  always_ff @(posedge clock_i) begin
    if (strobe_i.tck_rise) begin
      case (state_q)
        gpio_jtag_pkg::TAP_CAPTURE_IR:
          ir_shift_q <= {{(`IR_WIDTH - 1){1'b0}}, 1'b1};
        gpio_jtag_pkg::TAP_SHIFT_IR:
          ir_shift_q <= {strobe_i.tdi, ir_shift_q[`IR_WIDTH-1:1]};
        gpio_jtag_pkg::TAP_CAPTURE_DR:
          dr_shift_q <= dr_capture;
        gpio_jtag_pkg::TAP_SHIFT_DR:
          dr_shift_q <= dr_shifted;
        default: ;
      endcase
    end
  end

  assign shift_active = (state_q == gpio_jtag_pkg::TAP_SHIFT_IR) ||
                        (state_q == gpio_jtag_pkg::TAP_SHIFT_DR);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      tdo_q          <= 1'b0;
      upd_dr_entry_q <= 1'b0;
      write_strobe_q <= 1'b0;
    end else begin
      upd_dr_entry_q <= strobe_i.tck_rise && !strobe_i.trst &&
                        (state_next == gpio_jtag_pkg::TAP_UPDATE_DR);
      // write request one cycle after update-dr is entered
      write_strobe_q <= upd_dr_entry_q && (ir_q == `IR_GPIO_WRITE);
      // tdo moves on the falling edge, lsb of the active stage
      if (strobe_i.tck_fall) begin
        if (!shift_active) begin
          tdo_q <= 1'b0;
        end else if (state_q == gpio_jtag_pkg::TAP_SHIFT_IR) begin
          tdo_q <= ir_shift_q[0];
        end else begin
          tdo_q <= dr_shift_q[0];
        end
      end
    end
  end

  // driven only while shifting
  assign tdo_o = tdo_q & shift_active;

  // dr stage is frozen in update-dr, so it carries the write data
  assign gpio_write_o.strobe = write_strobe_q;
  assign gpio_write_o.data   = dr_shift_q[`GPIO_WIDTH-1:0];

  // strobe follows exactly one cycle of a fresh update-dr
  write_after_update_dr_a: assert property (
    @(posedge clock_i) disable iff (reset_i)
    gpio_write_o.strobe |->
      ($past(state_q) == gpio_jtag_pkg::TAP_UPDATE_DR) &&
      ($past(state_q, 2) != gpio_jtag_pkg::TAP_UPDATE_DR)
  );

endmodule

//--- verilog/jtag_pin_sampler.sv
`timescale 1ns/1ps

module jtag_pin_sampler (
  input  logic                        clock_i,
  input  logic                        reset_i,
  input  gpio_jtag_pkg::jtag_pins_t   pins_i,
  output gpio_jtag_pkg::jtag_strobe_t strobe_o
);

  // two-stage synchronizer for all four pins
  gpio_jtag_pkg::jtag_pins_t sync1_q;
  gpio_jtag_pkg::jtag_pins_t sync2_q;
  // previous synchronized tck, for edge detect
  logic                      tck_q3;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      // trst_n idles high, so no tap reset out of reset
      sync1_q  <= '{tck: 1'b0, tms: 1'b0, tdi: 1'b0, trst_n: 1'b1};
      sync2_q  <= '{tck: 1'b0, tms: 1'b0, tdi: 1'b0, trst_n: 1'b1};
      tck_q3   <= 1'b0;
      strobe_o <= '0;
    end else begin
      sync1_q <= pins_i;
      sync2_q <= sync1_q;
      tck_q3  <= sync2_q.tck;
      // edge pulses land three cycles after the pin edge
      strobe_o.tck_rise <= sync2_q.tck & ~tck_q3;
      strobe_o.tck_fall <= ~sync2_q.tck & tck_q3;
      // levels go through the same three flops
      strobe_o.tms  <= sync2_q.tms;
      strobe_o.tdi  <= sync2_q.tdi;
      // active-high trst for the tap
      strobe_o.trst <= ~sync2_q.trst_n;
    end
  end

  // a rising tck pin reaches the tap three cycles later
  tck_rise_latency_a: assert property (
    @(posedge clock_i) disable iff (reset_i)
    $rose(pins_i.tck) |-> ##3 strobe_o.tck_rise
  );

  // same for the falling edge
  tck_fall_latency_a: assert property (
    @(posedge clock_i) disable iff (reset_i)
    $fell(pins_i.tck) |-> ##3 strobe_o.tck_fall
  );

endmodule

//--- verilog/gpio_jtag_pkg.sv
`include "gpio_jtag_settings.svh"

package gpio_jtag_pkg;

  // ieee 1149.1 tap states, classic 4-bit encoding
  typedef enum logic [3:0] {
    TAP_EXIT2_DR   = 4'h0,
    TAP_EXIT1_DR   = 4'h1,
    TAP_SHIFT_DR   = 4'h2,
    TAP_PAUSE_DR   = 4'h3,
    TAP_SELECT_IR  = 4'h4,
    TAP_UPDATE_DR  = 4'h5,
    TAP_CAPTURE_DR = 4'h6,
    TAP_SELECT_DR  = 4'h7,
    TAP_EXIT2_IR   = 4'h8,
    TAP_EXIT1_IR   = 4'h9,
    TAP_SHIFT_IR   = 4'ha,
    TAP_PAUSE_IR   = 4'hb,
    TAP_RUN_IDLE   = 4'hc,
    TAP_UPDATE_IR  = 4'hd,
    TAP_CAPTURE_IR = 4'he,
    TAP_TLR        = 4'hf
  } tap_state_e;

  // raw jtag pins as seen at the top
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } jtag_pins_t;

  // pins after sync, tck reduced to edge pulses
  typedef struct packed {
    logic tck_rise;
    logic tck_fall;
    logic tms;
    logic tdi;
    logic trst;
  } jtag_strobe_t;

  // one-cycle write request towards the gpio output register
  typedef struct packed {
    logic                   strobe;
    logic [`GPIO_WIDTH-1:0] data;
  } gpio_write_t;

endpackage

//--- include/gpio_jtag_settings.svh
`ifndef GPIO_JTAG_SETTINGS_SVH
`define GPIO_JTAG_SETTINGS_SVH

// gpio pins in each direction
`define GPIO_WIDTH 20

// instruction register length and opcodes
`define IR_WIDTH       5
`define IR_IDCODE      5'h01
`define IR_GPIO_SAMPLE 5'h02
`define IR_GPIO_WRITE  5'h03
`define IR_BYPASS      5'h1f

// id word: version, part number, manufacturer, fixed one
`define JTAG_IDCODE {4'h0, 16'h4F54, 11'h426, 1'b1}

`endif
